// ==== bench/adpcm_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module adpcm_checker (
	input  logic        CLK_48M,
	input  logic        rst_n,
	input  logic        check,
	input  logic        timed_out,
	input  logic [7:0]  test_id,
	input  logic [1:0]  chans,
	input  logic [23:0] a_addr,
	input  logic [23:0] b_addr,
	input  logic [1:0]  exp_reqs,
	input  logic        en,
	input  logic [31:0] c_size,
	input  logic [31:0] v1_size,
	input  logic [31:0] v2_size,
	input  logic [7:0]  adpcma_data,
	input  logic [7:0]  adpcmb_data,
	input  logic        mem_req,
	output int          tests,
	output int          fails
);

	int          req_count;
	int          last_count;
	int          errs;
	logic        mem_req_q = 1'b0;
	logic [23:0] mask_a;
	logic [23:0] mask_b;
	logic [25:0] base_b;
	logic [7:0]  exp_a;
	logic [7:0]  exp_b;

	// Smallest all-ones value that covers offsets 0 to n-1
	function automatic logic [23:0] size_mask(input logic [31:0] n);
		logic [31:0] m;
		m = '0;
		if (n != '0) begin
			while (m < n - 1)
				m = {m[30:0], 1'b1};
		end
		return m[23:0];
	endfunction

	// Memory model word is the word address XOR a fixed pattern
	function automatic logic [7:0] rom_byte(input logic [25:0] base, input logic [23:0] off);
		logic [25:0] a;
		logic [31:0] w;
		a = base + {2'b00, off};
		w = {8'd0, a[25:2]} ^ 32'h5a5a_c3c3;
		w = w >> {off[1:0], 3'b000};
		return w[7:0];
	endfunction

	always_comb begin
		mask_a = size_mask(v1_size);
		mask_b = (v2_size == '0) ? mask_a : size_mask(v2_size);
		base_b = (v2_size == '0) ? c_size[25:0] : c_size[25:0] + v1_size[25:0];
		exp_a  = en ? rom_byte(c_size[25:0], a_addr & mask_a) : 8'h80;
		exp_b  = en ? rom_byte(base_b, b_addr & mask_b) : 8'h80;
	end

	always @(posedge CLK_48M) begin
		// A reset drop of mem_req is not a request
		if (rst_n && mem_req != mem_req_q)
			req_count <= req_count + 1;
		mem_req_q <= mem_req;
		if (check) begin
			errs = 0;
			if (timed_out) begin
				$display("test %0d: timed out waiting for ready", test_id);
				errs = 1;
			end else begin
				if (chans[0] && adpcma_data !== exp_a) begin
					$display("MISMATCH at %0t: test %0d channel A data %h, expected %h",
						$time, test_id, adpcma_data, exp_a);
					errs++;
				end
				if (chans[1] && adpcmb_data !== exp_b) begin
					$display("MISMATCH at %0t: test %0d channel B data %h, expected %h",
						$time, test_id, adpcmb_data, exp_b);
					errs++;
				end
				if (req_count - last_count != int'(exp_reqs)) begin
					$display("test %0d: expected %0d memory requests but saw %0d",
						test_id, exp_reqs, req_count - last_count);
					errs++;
				end
			end
			if (errs == 0)
				$display("test %0d: ok", test_id);
			else
				fails <= fails + 1;
			tests <= tests + 1;
			last_count <= req_count;
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_neo_adpcm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_neo_adpcm
	import neo_adpcm_pkg::*;
();

	localparam int N_TESTS = 12;

	logic        CLK_48M = 1'b0;
	logic        rst_n;
	download_t   dl;
	logic        adpcma_rd;
	logic [3:0]  adpcma_bank;
	logic [19:0] adpcma_addr;
	logic        adpcmb_rd;
	logic [23:0] adpcmb_addr;
	logic [7:0]  adpcma_data;
	logic        adpcma_ready;
	logic [7:0]  adpcmb_data;
	logic        adpcmb_ready;
	logic        mem_req;
	logic [25:0] mem_req_addr;
	logic        mem_ack = 1'b0;
	logic [31:0] mem_q = '0;
	logic [3:0]  mem_wait = '0;

	// Checker side
	logic        check;
	logic        timed_out;
	logic [7:0]  test_id;
	logic [1:0]  chans;
	logic [23:0] a_addr;
	logic [23:0] b_addr;
	logic [1:0]  exp_reqs;
	logic        en;
	logic [31:0] c_size;
	logic [31:0] v1_size;
	logic [31:0] v2_size;
	int          tests;
	int          fails;

	// Header variants: index (0 is no download), C, V1 and V2 sizes
	logic [7:0]  hv_index [4] = '{8'd0, 8'd1, 8'd1, 8'd2};
	logic [31:0] hv_c     [4] = '{32'h0, 32'h40000, 32'h40000, 32'h40000};
	logic [31:0] hv_v1    [4] = '{32'h0, 32'h30000, 32'h30000, 32'h30000};
	logic [31:0] hv_v2    [4] = '{32'h0, 32'h12000, 32'h0, 32'h12000};

	// Columns: header variant, channels (bit 0 A, bit 1 B), A address, B address,
	// memory requests expected
	int          t_hdr  [N_TESTS] = '{0, 1, 1, 1, 1, 1, 1, 1, 2, 2, 2, 3};
	logic [1:0]  t_chan [N_TESTS] = '{2'd3, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2,
	                                  2'd3, 2'd3, 2'd2, 2'd3, 2'd2, 2'd3};
	logic [23:0] t_a    [N_TESTS] = '{24'h000104, 24'h012345, 24'h012346, 24'h07abcd,
	                                  24'h0, 24'h0, 24'h020000, 24'h020003,
	                                  24'h0, 24'h010010, 24'h0, 24'h012345};
	logic [23:0] t_b    [N_TESTS] = '{24'h000208, 24'h0, 24'h0, 24'h0,
	                                  24'h01fff0, 24'h0abcd1, 24'h004004, 24'h004008,
	                                  24'h02a5a4, 24'h010020, 24'h010021, 24'h001234};
	logic [1:0]  t_reqs [N_TESTS] = '{2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1,
	                                  2'd2, 2'd1, 2'd1, 2'd2, 2'd0, 2'd0};

	neo_adpcm_rom_top u_dut (.*);

	adpcm_checker u_check (.*);

	initial begin
		forever #10 CLK_48M = ~CLK_48M;
	end

	// Sample memory answers each toggle after 1 to 8 cycles
	always @(negedge CLK_48M) begin
		if (!rst_n) begin
			mem_ack  <= 1'b0;
			mem_wait <= '0;
		end else if (mem_req != mem_ack) begin
			if (mem_wait == '0) begin
				mem_wait <= 4'd1 + 4'($urandom % 8);
			end else if (mem_wait == 4'd1) begin
				mem_q    <= {8'd0, mem_req_addr[25:2]} ^ 32'h5a5a_c3c3;
				mem_ack  <= mem_req;
				mem_wait <= '0;
			end else begin
				mem_wait <= mem_wait - 4'd1;
			end
		end
	end

	task automatic apply_reset();
		@(negedge CLK_48M);
		rst_n = 1'b0;
		repeat (5) @(negedge CLK_48M);
		rst_n = 1'b1;
	endtask

	// Full 4 KiB header block, sizes little endian from byte 4
	task automatic send_header(input logic [7:0] index, input logic [31:0] c_val,
			input logic [31:0] v1_val, input logic [31:0] v2_val);
		logic [31:0] sizes [6];
		logic [31:0] word;
		int          fld;
		sizes = '{32'h0010_0000, 32'h0002_0000, 32'h0004_0000, v1_val, v2_val, c_val};
		for (int a = 0; a < 4096; a++) begin
			@(negedge CLK_48M);
			dl.downl = 1'b1;
			dl.index = index;
			dl.wr    = 1'b1;
			dl.addr  = 27'(a);
			dl.dout  = 8'h00;
			if (a >= 4 && a < 28) begin
				fld     = (a - 4) / 4;
				word    = sizes[fld] >> (8 * ((a - 4) % 4));
				dl.dout = word[7:0];
			end
		end
		@(negedge CLK_48M);
		dl = '0;
	endtask

	task automatic start_read(input logic [1:0] sel, input logic [23:0] a, input logic [23:0] b);
		@(negedge CLK_48M);
		adpcma_bank = a[23:20];
		adpcma_addr = a[19:0];
		adpcmb_addr = b;
		adpcma_rd   = sel[0];
		adpcmb_rd   = sel[1];
		@(negedge CLK_48M);
		adpcma_rd = 1'b0;
		adpcmb_rd = 1'b0;
	endtask

	task automatic wait_ready(output bit ok);
		int cycles;
		cycles = 0;
		while (!(adpcma_ready && adpcmb_ready) && cycles < 100) begin
			@(negedge CLK_48M);
			cycles++;
		end
		ok = adpcma_ready && adpcmb_ready;
	endtask

	task automatic pulse_check(input int id, input bit late);
		test_id   = 8'(id);
		timed_out = late;
		check     = 1'b1;
		@(negedge CLK_48M);
		check = 1'b0;
	endtask

	initial begin
		int prev_hdr;
		bit aborted;
		bit ok;
		prev_hdr = -1;
		aborted  = 1'b0;
		void'($urandom(32'h0f86b37b));
		rst_n       = 1'b0;
		dl          = '0;
		adpcma_rd   = 1'b0;
		adpcma_bank = '0;
		adpcma_addr = '0;
		adpcmb_rd   = 1'b0;
		adpcmb_addr = '0;
		check       = 1'b0;
		timed_out   = 1'b0;
		test_id     = '0;
		chans       = '0;
		a_addr      = '0;
		b_addr      = '0;
		exp_reqs    = '0;
		en          = 1'b0;
		c_size      = '0;
		v1_size     = '0;
		v2_size     = '0;
		for (int i = 0; i < N_TESTS && !aborted; i++) begin
			if (t_hdr[i] != prev_hdr) begin
				apply_reset();
				if (hv_index[t_hdr[i]] != 8'd0)
					send_header(hv_index[t_hdr[i]], hv_c[t_hdr[i]], hv_v1[t_hdr[i]],
						hv_v2[t_hdr[i]]);
				prev_hdr = t_hdr[i];
			end
			en       = hv_index[t_hdr[i]] == 8'd1;
			c_size   = hv_c[t_hdr[i]];
			v1_size  = hv_v1[t_hdr[i]];
			v2_size  = hv_v2[t_hdr[i]];
			chans    = t_chan[i];
			a_addr   = t_a[i];
			b_addr   = t_b[i];
			exp_reqs = t_reqs[i];
			start_read(t_chan[i], t_a[i], t_b[i]);
			wait_ready(ok);
			pulse_check(i, !ok);
			if (!ok)
				aborted = 1'b1;
		end
		// Let the checker tally the last test
		@(negedge CLK_48M);
		$display("%0d tests run, %0d failed", tests, fails);
		if (fails == 0 && !aborted && tests == N_TESTS) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/adpcm_sample_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_adpcm_defines.svh"

module adpcm_sample_fetch
	import neo_adpcm_pkg::*;
(
	input  logic                   CLK_48M,
	input  logic                   rst_n,
	input  logic                   rd,
	input  logic [`NEO_SMP_AW-1:0] addr,
	input  sample_window_t         win,
	input  logic                   adpcm_en,
	output sample_req_t            req,
	input  sample_rsp_t            rsp,
	output logic [7:0]             data,
	output logic                   ready
);

	logic                   rd_q;
	logic                   rd_rise;
	logic                   req_tgl;
	logic [`NEO_SMP_AW-1:0] latch;

	assign rd_rise = rd && !rd_q;

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			rd_q    <= 1'b0;
			req_tgl <= 1'b0;
			latch   <= '0;
		end else begin
			rd_q <= rd;
			if (rd_rise && adpcm_en) begin
				// Raw address against the masked latch, as the chip sees it
				if (addr[`NEO_SMP_AW-1:2] != latch[`NEO_SMP_AW-1:2])
					req_tgl <= ~req_tgl;
				latch <= addr & win.mask;
			end
		end
	end

	assign req   = '{req: req_tgl, addr: win.base + {2'b00, latch}};
	assign ready = req_tgl == rsp.ack;

	always_comb begin
		if (!adpcm_en) begin
			data = `NEO_SILENCE;
		end else begin
			case (latch[1:0])
				2'd0: data = rsp.word[7:0];
				2'd1: data = rsp.word[15:8];
				2'd2: data = rsp.word[23:16];
				default: data = rsp.word[31:24];
			endcase
		end
	end

	// Arbiter only answers an outstanding request
	a_ack_pending: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		$changed(rsp.ack) |-> $past(req.req != rsp.ack)
	) else $error("ack toggled with no pending request");

	// A second toggle before the ack would cancel the first
	a_one_in_flight: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		$changed(req.req) |-> $past(ready)
	) else $error("request toggled while a fetch is pending");

endmodule

`default_nettype wire

// ==== hw/neo_adpcm_defines.svh ====
`ifndef NEO_ADPCM_DEFINES_SVH
`define NEO_ADPCM_DEFINES_SVH

// Cartridge header layout
// Six 32-bit sizes P, S, M, V1, V2, C start at byte 4
`define NEO_HDR_FIRST 4
`define NEO_HDR_LAST 28

// Last byte of the 4 KiB header block
`define NEO_HDR_END 12'hfff

// Width of one size field in the header
`define NEO_SIZE_W 32

// Byte returned while ADPCM is off
`define NEO_SILENCE 8'h80

// Sample address as seen by the sound chip
`define NEO_SMP_AW 24

// Byte address into sample ROM and its word width
`define NEO_MEM_AW 26
`define NEO_WORD_W 32

`endif

// ==== hw/neo_adpcm_pkg.sv ====
`default_nettype none

`include "neo_adpcm_defines.svh"

package neo_adpcm_pkg;

	// Cartridge download stream, one byte per wr strobe
	typedef struct packed {
		logic        downl;
		logic [7:0]  index;
		logic        wr;
		logic [26:0] addr;
		logic [7:0]  dout;
	} download_t;

	// Where one channel's samples sit in ROM
	typedef struct packed {
		logic [`NEO_MEM_AW-1:0] base;
		logic [`NEO_SMP_AW-1:0] mask;
	} sample_window_t;

	// Channel to arbiter, req is a toggle
	typedef struct packed {
		logic                   req;
		logic [`NEO_MEM_AW-1:0] addr;
	} sample_req_t;

	// Arbiter to channel, ack follows req once the word is held
	typedef struct packed {
		logic                   ack;
		logic [`NEO_WORD_W-1:0] word;
	} sample_rsp_t;

endpackage

`default_nettype wire

// ==== hw/neo_adpcm_rom_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_adpcm_defines.svh"

module neo_adpcm_rom_top
	import neo_adpcm_pkg::*;
(
	input  logic                   CLK_48M,
	input  logic                   rst_n,
	input  download_t              dl,
	input  logic                   adpcma_rd,
	input  logic [3:0]             adpcma_bank,
	input  logic [19:0]            adpcma_addr,
	input  logic                   adpcmb_rd,
	input  logic [`NEO_SMP_AW-1:0] adpcmb_addr,
	output logic [7:0]             adpcma_data,
	output logic                   adpcma_ready,
	output logic [7:0]             adpcmb_data,
	output logic                   adpcmb_ready,
	output logic                   mem_req,
	output logic [`NEO_MEM_AW-1:0] mem_req_addr,
	input  logic                   mem_ack,
	input  logic [`NEO_WORD_W-1:0] mem_q
);

	sample_window_t win_a;
	sample_window_t win_b;
	logic           adpcm_en;
	sample_req_t    req_a;
	sample_req_t    req_b;
	sample_rsp_t    rsp_a;
	sample_rsp_t    rsp_b;

	neo_cart_header u_header (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.dl       (dl),
		.win_a    (win_a),
		.win_b    (win_b),
		.adpcm_en (adpcm_en)
	);

	// ADPCM-A address is bank on top of the 20-bit offset
	adpcm_sample_fetch u_chan_a (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.rd       (adpcma_rd),
		.addr     ({adpcma_bank, adpcma_addr}),
		.win      (win_a),
		.adpcm_en (adpcm_en),
		.req      (req_a),
		.rsp      (rsp_a),
		.data     (adpcma_data),
		.ready    (adpcma_ready)
	);

	adpcm_sample_fetch u_chan_b (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.rd       (adpcmb_rd),
		.addr     (adpcmb_addr),
		.win      (win_b),
		.adpcm_en (adpcm_en),
		.req      (req_b),
		.rsp      (rsp_b),
		.data     (adpcmb_data),
		.ready    (adpcmb_ready)
	);

	sample_rom_arbiter u_arb (
		.CLK_48M      (CLK_48M),
		.rst_n        (rst_n),
		.req_a        (req_a),
		.req_b        (req_b),
		.rsp_a        (rsp_a),
		.rsp_b        (rsp_b),
		.mem_req      (mem_req),
		.mem_req_addr (mem_req_addr),
		.mem_ack      (mem_ack),
		.mem_q        (mem_q)
	);

endmodule

`default_nettype wire

// ==== hw/neo_cart_header.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_adpcm_defines.svh"

module neo_cart_header
	import neo_adpcm_pkg::*;
(
	input  logic           CLK_48M,
	input  logic           rst_n,
	input  download_t      dl,
	output sample_window_t win_a,
	output sample_window_t win_b,
	output logic           adpcm_en
);

	logic                          cart_wr;
	logic                          in_sizes;
	logic                          hdr_end;
	logic [6*`NEO_SIZE_W-1:0]      size_sr;
	logic [`NEO_SIZE_W-1:0]        v1_size;
	logic [`NEO_SIZE_W-1:0]        v2_size;
	logic [`NEO_SIZE_W-1:0]        c_size;
	logic [`NEO_SMP_AW-1:0]        v1_mask;
	logic [`NEO_SMP_AW-1:0]        v2_mask;
	logic [`NEO_MEM_AW-1:0]        base_a;
	logic [`NEO_MEM_AW-1:0]        base_b;
	logic                          merged;

	// 2^k - 1, k is the top set bit, plus one when n is not a power of two
	function automatic logic [`NEO_SMP_AW-1:0] ceil_mask(input logic [`NEO_SIZE_W-1:0] n);
		int         top;
		int         ones;
		logic [`NEO_SIZE_W:0] full;
		top = 0;
		ones = 0;
		for (int i = 0; i < `NEO_SIZE_W; i++) begin
			if (n[i]) begin
				top = i;
				ones++;
			end
		end
		if (ones > 1)
			top = top + 1;
		full = ((`NEO_SIZE_W+1)'(1) << top) - 1'b1;
		return full[`NEO_SMP_AW-1:0];
	endfunction

	// Only cart images, and only the first 4 KiB
	assign cart_wr  = dl.downl && dl.wr && (dl.index == 8'd1 || dl.index == 8'd2) &&
	                  dl.addr[26:12] == '0;
	assign in_sizes = dl.addr[11:0] >= `NEO_HDR_FIRST && dl.addr[11:0] < `NEO_HDR_LAST;
	assign hdr_end  = dl.addr[11:0] == `NEO_HDR_END;

	// Field order P, S, M, V1, V2, C from low to high
	assign v1_size = size_sr[4*`NEO_SIZE_W-1:3*`NEO_SIZE_W];
	assign v2_size = size_sr[5*`NEO_SIZE_W-1:4*`NEO_SIZE_W];
	assign c_size  = size_sr[6*`NEO_SIZE_W-1:5*`NEO_SIZE_W];

	// Little endian, newest byte enters at the top
	always_ff @(posedge CLK_48M) begin
		if (cart_wr && in_sizes)
			size_sr <= {dl.dout, size_sr[6*`NEO_SIZE_W-1:8]};
	end

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			merged   <= 1'b0;
			adpcm_en <= 1'b0;
			v1_mask  <= '0;
			v2_mask  <= '0;
			base_a   <= '0;
			base_b   <= '0;
		end else if (cart_wr && hdr_end) begin
			v1_mask  <= ceil_mask(v1_size);
			v2_mask  <= ceil_mask(v2_size);
			merged   <= v2_size == '0;
			adpcm_en <= dl.index == 8'd1;
			base_a   <= c_size[`NEO_MEM_AW-1:0];
			// Merged images keep both sample sets in V1
			if (v2_size == '0)
				base_b <= c_size[`NEO_MEM_AW-1:0];
			else
				base_b <= c_size[`NEO_MEM_AW-1:0] + v1_size[`NEO_MEM_AW-1:0];
		end
	end

	assign win_a = '{base: base_a, mask: v1_mask};
	assign win_b = '{base: base_b, mask: merged ? v1_mask : v2_mask};

endmodule

`default_nettype wire

// ==== hw/sample_rom_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "neo_adpcm_defines.svh"

module sample_rom_arbiter
	import neo_adpcm_pkg::*;
(
	input  logic                   CLK_48M,
	input  logic                   rst_n,
	input  sample_req_t            req_a,
	input  sample_req_t            req_b,
	output sample_rsp_t            rsp_a,
	output sample_rsp_t            rsp_b,
	output logic                   mem_req,
	output logic [`NEO_MEM_AW-1:0] mem_req_addr,
	input  logic                   mem_ack,
	input  logic [`NEO_WORD_W-1:0] mem_q
);

	logic                   pend_a;
	logic                   pend_b;
	logic                   grant_b;
	logic                   last_b;
	logic                   busy;
	logic                   owner_b;
	logic                   mem_tgl;
	logic                   ack_a;
	logic                   ack_b;
	logic [`NEO_MEM_AW-1:0] mem_addr_q;
	logic [`NEO_WORD_W-1:0] word_a;
	logic [`NEO_WORD_W-1:0] word_b;

	assign pend_a = req_a.req != ack_a;
	assign pend_b = req_b.req != ack_b;

	// B wins if alone or if A had the last turn
	assign grant_b = pend_b && (!pend_a || !last_b);

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			last_b     <= 1'b1;
			busy       <= 1'b0;
			owner_b    <= 1'b0;
			mem_tgl    <= 1'b0;
			ack_a      <= 1'b0;
			ack_b      <= 1'b0;
			mem_addr_q <= '0;
		end else if (!busy) begin
			if (pend_a || pend_b) begin
				busy    <= 1'b1;
				owner_b <= grant_b;
				last_b  <= grant_b;
				mem_tgl <= ~mem_tgl;
				mem_addr_q <= {grant_b ? req_b.addr[`NEO_MEM_AW-1:2] :
				                         req_a.addr[`NEO_MEM_AW-1:2], 2'b00};
			end
		end else if (mem_ack == mem_tgl) begin
			busy <= 1'b0;
			if (owner_b)
				ack_b <= ~ack_b;
			else
				ack_a <= ~ack_a;
		end
	end

	// Word lands together with the ack toggle
	always_ff @(posedge CLK_48M) begin
		if (busy && mem_ack == mem_tgl) begin
			if (owner_b)
				word_b <= mem_q;
			else
				word_a <= mem_q;
		end
	end

	assign mem_req      = mem_tgl;
	assign mem_req_addr = mem_addr_q;
	assign rsp_a        = '{ack: ack_a, word: word_a};
	assign rsp_b        = '{ack: ack_b, word: word_b};

	a_word_aligned: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		mem_req_addr[1:0] == 2'b00
	) else $error("memory address not word aligned");

	// Memory must have answered the last toggle first
	a_single_flight: assert property (
		@(posedge CLK_48M) disable iff (!rst_n)
		$changed(mem_req) |-> $past(mem_req == mem_ack)
	) else $error("memory request issued while another is in flight");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then decide from the log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
	--top-module tb_neo_adpcm -Mdir obj_dir -o tb_neo_adpcm > build.log 2>&1 ||
	{ cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_neo_adpcm > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// ==== sim.f ====
+incdir+hw
hw/neo_adpcm_pkg.sv
hw/neo_cart_header.sv
hw/adpcm_sample_fetch.sv
hw/sample_rom_arbiter.sv
hw/neo_adpcm_rom_top.sv
bench/adpcm_checker.sv
bench/tb_neo_adpcm.sv
